// ==== verilog.f ====
verilog/blueprint_pkg.sv
verilog/bus_decode.sv
verilog/bus_execute.sv
verilog/bus_result.sv
verilog/video_timing.sv
verilog/main_bus_top.sv
sim/tb_main_bus.sv

// ==== Makefile ====
# Verilator build and run of the main bus testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module tb_main_bus
	@out=$$(./obj_dir/Vtb_main_bus); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// ==== sim/tb_main_bus.sv ====
//----------------------------
// Main bus testbench
// Wishbone accesses, video timing and frame interrupt
//----------------------------
`default_nettype none

module tb_main_bus;

	localparam int H_CENTER = 5;   // Small enough that hsync ends inside the line
	localparam int V_CENTER = 3;

	logic        clk_49m;
	logic        reset;
	logic        cyc_i, stb_i, we_i, ack_o;
	logic [15:0] adr_i;
	logic [7:0]  dat_i, dat_o, p1_controls_i, p2_controls_i, dipsw_i, sound_cmd_o;
	logic        sound_cmd_wr_o, flip_o, gfx_bank_o, irq_ack_i, irq_n_o;
	logic [3:0]  h_center_i, v_center_i;
	logic        ce_pix_o, hblank_o, vblank_o, hsync_o, vsync_o, csync_o;

	int    seed = 93667;
	int    errors, errs_at_start, tests, tests_failed;
	string test_name;
	logic [7:0] exp_dat, exp_snd;   // Expectations travel with the access
	logic       rd_chk, exp_flip, exp_bank;

	// Video observers
	logic hblank_d, hs_seen, line_done, line_vb, hsync_d, vsync_d, frame_done;
	int   ce_cnt, blank_cnt, hs_cnt, hs_dly, lines;
	int   line_ce, line_blank, line_hs, line_dly, line_v;
	int   vs_hs, vs_hs_last, frames;

	main_bus_top DUT (.*);

	initial begin
		clk_49m = 1'b0;
		forever #10 clk_49m = ~clk_49m;
	end

	//----------------------------
	// Bus and flow tasks
	//----------------------------
	task automatic timeout_fail(input string what);
		$display("Timeout while waiting for %s", what);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	// One Wishbone access started on a rising edge
	task automatic bus_cycle(input logic we, input logic [15:0] adr, input logic [7:0] dat,
		input logic [7:0] exp, input logic chk);
		int n;
		cyc_i   <= 1'b1;
		stb_i   <= 1'b1;
		we_i    <= we;
		adr_i   <= adr;
		dat_i   <= dat;
		exp_dat <= exp;
		rd_chk  <= chk;
		n = 0;
		do begin
			@(posedge clk_49m);
			n++;
		end while (!ack_o && n < 20);
		if (!ack_o)
			timeout_fail("ack_o");
		cyc_i <= 1'b0;            // Strobe low for at least one cycle
		stb_i <= 1'b0;
		we_i  <= 1'b0;
		@(posedge clk_49m);
	endtask

	task automatic wait_lines(input int count);
		int target;
		int n;
		target = lines + count;
		n = 0;
		while (lines < target && n < count * 4000) begin
			@(posedge clk_49m);
			n++;
		end
		if (lines < target)
			timeout_fail("video lines");
	endtask

	task automatic wait_frame();
		int target;
		int n;
		target = frames + 1;
		n = 0;
		while (frames < target && n < 1200000) begin   // Frame is about 830k clocks
			@(posedge clk_49m);
			n++;
		end
		if (frames < target)
			timeout_fail("end of vsync");
	endtask

	task automatic wait_irq(input logic level, input int limit);
		int n;
		n = 0;
		while (irq_n_o != level && n < limit) begin
			@(posedge clk_49m);
			n++;
		end
		if (irq_n_o != level)
			timeout_fail("irq_n_o");
	endtask

	task automatic pulse_irq_ack();
		irq_ack_i <= 1'b1;
		@(posedge clk_49m);
		irq_ack_i <= 1'b0;
	endtask

	task automatic start_test(input string name);
		test_name     = name;
		errs_at_start = errors;
	endtask

	task automatic end_test();
		repeat (3) @(posedge clk_49m);   // Let the last checks settle
		tests++;
		if (errors != errs_at_start)
			tests_failed++;
		$display("test %s done, %0d errors", test_name, errors - errs_at_start);
	endtask

	task automatic end_run();
		$display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	endtask

	//----------------------------
	// Line and frame observers
	//----------------------------
	always @(posedge clk_49m) begin
		if (!reset) begin
			{hblank_d, hs_seen, line_done, line_vb} <= 4'b0000;
			{ce_cnt, blank_cnt, hs_cnt, hs_dly, lines} <= '0;
			{line_ce, line_blank, line_hs, line_dly, line_v} <= '0;
		end else begin
			hblank_d  <= hblank_o;
			line_done <= 1'b0;
			if (hblank_d && !hblank_o) begin   // h_cnt wrapped to 0
				line_ce    <= ce_cnt;
				line_blank <= blank_cnt;
				line_hs    <= hs_cnt;
				line_dly   <= hs_dly;
				line_vb    <= vblank_o;          // First cycle of the new line
				line_v     <= (lines + 1) % 264; // Raster starts at line 0 after reset
				line_done  <= (lines != 0);      // Skip the line that reset cut into
				lines      <= lines + 1;
				{ce_cnt, blank_cnt, hs_cnt, hs_dly} <= '0;
				hs_seen    <= 1'b0;
			end else if (ce_pix_o) begin
				ce_cnt <= ce_cnt + 1;
				if (hblank_o)
					blank_cnt <= blank_cnt + 1;
				if (hblank_o && !hsync_o && !hs_seen)
					hs_dly <= hs_dly + 1;        // Blank pulses before hsync
				if (hsync_o) begin
					hs_cnt  <= hs_cnt + 1;
					hs_seen <= 1'b1;
				end
			end
		end
	end

	always @(posedge clk_49m) begin
		if (!reset) begin
			{hsync_d, vsync_d, frame_done} <= 3'b000;
			{vs_hs, vs_hs_last, frames} <= '0;
		end else begin
			hsync_d    <= hsync_o;
			vsync_d    <= vsync_o;
			frame_done <= 1'b0;
			if (vsync_d && !vsync_o) begin
				vs_hs_last <= vs_hs;
				vs_hs      <= 0;
				frame_done <= 1'b1;
				frames     <= frames + 1;
			end else if (vsync_o && hsync_o && !hsync_d) begin
				vs_hs <= vs_hs + 1;              // hsync rise inside vsync
			end
		end
	end

	//----------------------------
	// Checks
	//----------------------------
	a_ack_early: assert property (@(posedge clk_49m) disable iff (!reset)
		$rose(cyc_i && stb_i) |=> !ack_o)
	else begin
		errors++;
		$display("ack_o came one cycle too early in %s", test_name);
	end
	a_ack_time: assert property (@(posedge clk_49m) disable iff (!reset)
		$rose(cyc_i && stb_i) |-> ##2 ack_o)
	else begin
		errors++;
		$display("ack_o missing two cycles after strobe in %s", test_name);
	end
	a_ack_once: assert property (@(posedge clk_49m) disable iff (!reset) ack_o |=> !ack_o)
	else begin
		errors++;
		$display("ack_o stayed high for two cycles in %s", test_name);
	end
	a_rd_data: assert property (@(posedge clk_49m) disable iff (!reset)
		ack_o && rd_chk |-> dat_o == exp_dat)
	else begin
		errors++;
		$display("** Error %s: dat_o expected %02h, actual %02h", test_name, exp_dat, dat_o);
	end
	a_snd_data: assert property (@(posedge clk_49m) disable iff (!reset)
		sound_cmd_wr_o |-> sound_cmd_o == exp_snd)
	else begin
		errors++;
		$display("** Error %s: sound_cmd_o expected %02h, actual %02h", test_name, exp_snd,
			sound_cmd_o);
	end
	a_snd_strobe: assert property (@(posedge clk_49m) disable iff (!reset)
		$rose(cyc_i && stb_i) && we_i && adr_i == 16'hD000 |=> sound_cmd_wr_o)
	else begin
		errors++;
		$display("sound_cmd_wr_o did not pulse in %s", test_name);
	end
	a_snd_single: assert property (@(posedge clk_49m) disable iff (!reset)
		sound_cmd_wr_o |=> !sound_cmd_wr_o)
	else begin
		errors++;
		$display("sound_cmd_wr_o longer than one cycle in %s", test_name);
	end
	a_ctrl: assert property (@(posedge clk_49m) disable iff (!reset)
		$rose(cyc_i && stb_i) && we_i && adr_i == 16'hE000 |=>
		flip_o == exp_flip && gfx_bank_o == exp_bank)
	else begin
		errors++;
		$display("** Error %s: flip,bank expected %b%b, actual %b%b", test_name, exp_flip,
			exp_bank, flip_o, gfx_bank_o);
	end
	a_line: assert property (@(posedge clk_49m) disable iff (!reset)
		line_done |-> line_ce == 320 && line_blank == 64)
	else begin
		errors++;
		$display("** Error %s: pulses per line,blank expected 320,64, actual %0d,%0d",
			test_name, line_ce, line_blank);
	end
	a_hsync: assert property (@(posedge clk_49m) disable iff (!reset)
		line_done |-> line_hs == 32 && line_dly == 24 + H_CENTER)
	else begin
		errors++;
		$display("** Error %s: hsync length,delay expected 32,%0d, actual %0d,%0d",
			test_name, 24 + H_CENTER, line_hs, line_dly);
	end
	// Vertical blank covers lines 0 to 15 and 240 to 263
	a_vblank: assert property (@(posedge clk_49m) disable iff (!reset)
		line_done |-> line_vb == (line_v < 16 || line_v >= 240))
	else begin
		errors++;
		$display("** Error %s: vblank_o on line %0d expected %b, actual %b", test_name,
			line_v, line_v < 16 || line_v >= 240, line_vb);
	end
	a_vsync: assert property (@(posedge clk_49m) disable iff (!reset)
		frame_done |-> vs_hs_last == 4)
	else begin
		errors++;
		$display("** Error %s: hsync pulses in vsync expected 4, actual %0d", test_name,
			vs_hs_last);
	end
	a_irq_fall: assert property (@(posedge clk_49m) disable iff (!reset)
		$rose(vblank_o) && !irq_ack_i |=> !irq_n_o)
	else begin
		errors++;
		$display("irq_n_o did not fall after vblank_o rose");
	end
	a_irq_hold: assert property (@(posedge clk_49m) disable iff (!reset)
		!irq_n_o && !irq_ack_i |=> !irq_n_o)
	else begin
		errors++;
		$display("irq_n_o released without an acknowledge");
	end
	a_irq_ack: assert property (@(posedge clk_49m) disable iff (!reset) irq_ack_i |=> irq_n_o)
	else begin
		errors++;
		$display("irq_n_o not released by irq_ack_i");
	end
	a_csync: assert property (@(posedge clk_49m) disable iff (!reset)
		csync_o == !(hsync_o ^ vsync_o))
	else begin
		errors++;
		$display("csync_o does not match hsync_o and vsync_o");
	end

	//----------------------------
	// Stimulus
	//----------------------------
	initial begin
		int          i;
		logic [15:0] wa [16];
		logic [7:0]  wd [16];
		logic [7:0]  d;
		{reset, cyc_i, stb_i, we_i, irq_ack_i} = 5'b00000;
		{adr_i, dat_i} = '0;
		{p1_controls_i, p2_controls_i, dipsw_i} = '0;
		{exp_dat, exp_snd, rd_chk, exp_flip, exp_bank} = '0;
		{errors, errs_at_start, tests, tests_failed} = '0;
		h_center_i = 4'(H_CENTER);
		v_center_i = 4'(V_CENTER);
		repeat (5) @(posedge clk_49m);
		reset <= 1'b1;
		@(posedge clk_49m);

		start_test("wram");
		for (i = 0; i < 16; i++) begin
			wa[i] = {5'b10000, i[3:0], 7'($random(seed))};   // Distinct addresses
			wd[i] = 8'($random(seed));
			bus_cycle(1'b1, wa[i], wd[i], 8'h00, 1'b0);
		end
		for (i = 0; i < 16; i++)
			bus_cycle(1'b0, wa[i], 8'h00, wd[i], 1'b1);
		bus_cycle(1'b0, 16'h8800, 8'h00, 8'hFF, 1'b1);     // Just above work RAM
		bus_cycle(1'b0, 16'hF000, 8'h00, 8'hFF, 1'b1);
		for (i = 0; i < 4; i++)
			bus_cycle(1'b0, {1'b0, 15'($random(seed))}, 8'h00, 8'hFF, 1'b1);
		end_test();

		start_test("inputs");
		for (i = 0; i < 3; i++)
			wd[i] = 8'($random(seed));
		p1_controls_i <= wd[0];
		p2_controls_i <= wd[1];
		dipsw_i       <= wd[2];
		bus_cycle(1'b0, 16'hC000, 8'h00, wd[0], 1'b1);
		bus_cycle(1'b0, 16'hC001, 8'h00, wd[1], 1'b1);
		bus_cycle(1'b0, 16'hC003, 8'h00, wd[2], 1'b1);
		bus_cycle(1'b0, 16'hC002, 8'h00, 8'hFF, 1'b1);     // No port on select 2
		end_test();

		start_test("board");
		for (i = 0; i < 3; i++) begin
			d = 8'($random(seed));
			exp_snd <= d;
			bus_cycle(1'b1, 16'hD000, d, 8'h00, 1'b0);
		end
		for (i = 0; i < 4; i++) begin
			d = (i < 2) ? 8'h02 << i : 8'($random(seed));   // Both flip levels first
			exp_flip <= ~d[1];
			exp_bank <= d[2];
			bus_cycle(1'b1, 16'hE000, d, 8'h00, 1'b0);
		end
		bus_cycle(1'b0, 16'hD000, 8'h00, 8'hFF, 1'b1);
		bus_cycle(1'b0, 16'hE000, 8'h00, 8'hFF, 1'b1);
		end_test();

		start_test("line");
		wait_lines(3);
		end_test();

		start_test("frame");
		pulse_irq_ack();                   // Clear the edge seen right after reset
		wait_irq(1'b1, 10);
		wait_irq(1'b0, 1200000);           // vblank starts at line 240
		wait_frame();
		pulse_irq_ack();
		wait_irq(1'b1, 10);
		end_test();

		end_run();
	end

endmodule

`default_nettype wire

// ==== verilog/main_bus_top.sv ====
//----------------------------
// Blue Print main board, bus side
// Wishbone slave plus video timing
//----------------------------
`default_nettype none

module main_bus_top (
	input  wire                                clk_49m,
	input  wire                                reset,      // Active low
	// Wishbone slave
	input  wire                                cyc_i,
	input  wire                                stb_i,
	input  wire                                we_i,
	input  wire  [blueprint_pkg::ADDR_W-1:0]   adr_i,
	input  wire  [blueprint_pkg::DATA_W-1:0]   dat_i,
	output logic [blueprint_pkg::DATA_W-1:0]   dat_o,
	output logic                               ack_o,
	// Board I/O
	input  wire  [blueprint_pkg::DATA_W-1:0]   p1_controls_i,
	input  wire  [blueprint_pkg::DATA_W-1:0]   p2_controls_i,
	input  wire  [blueprint_pkg::DATA_W-1:0]   dipsw_i,
	output logic [blueprint_pkg::DATA_W-1:0]   sound_cmd_o,
	output logic                               sound_cmd_wr_o,
	output logic                               flip_o,
	output logic                               gfx_bank_o,
	// Video
	input  wire  [blueprint_pkg::CENTER_W-1:0] h_center_i,
	input  wire  [blueprint_pkg::CENTER_W-1:0] v_center_i,
	input  wire                                irq_ack_i,
	output logic                               irq_n_o,
	output logic                               ce_pix_o,
	output logic                               hblank_o,
	output logic                               vblank_o,
	output logic                               hsync_o,
	output logic                               vsync_o,
	output logic                               csync_o
);

	logic [blueprint_pkg::REGION_W-1:0] dec_region;   // Live decode of adr_i
	logic [1:0]                         dec_port_sel;
	logic                               exe_done;
	logic [blueprint_pkg::REGION_W-1:0] exe_region;   // Latched at acceptance
	logic [1:0]                         exe_port_sel;
	logic [blueprint_pkg::DATA_W-1:0]   wram_q;

	//----------------------------
	// Bus slave
	//----------------------------
	bus_decode u_decode (
		.adr_i(adr_i), .region_o(dec_region), .port_sel_o(dec_port_sel)
	);

	bus_execute u_execute (
		.clk_49m(clk_49m), .reset(reset),
		.cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i), .adr_i(adr_i), .dat_i(dat_i),
		.region_i(dec_region), .port_sel_i(dec_port_sel),
		.done_o(exe_done), .region_o(exe_region), .port_sel_o(exe_port_sel),
		.wram_q_o(wram_q),
		.sound_cmd_o(sound_cmd_o), .sound_cmd_wr_o(sound_cmd_wr_o),
		.flip_o(flip_o), .gfx_bank_o(gfx_bank_o)
	);

	bus_result u_result (
		.clk_49m(clk_49m), .reset(reset),
		.done_i(exe_done), .region_i(exe_region), .port_sel_i(exe_port_sel),
		.wram_q_i(wram_q),
		.p1_controls_i(p1_controls_i), .p2_controls_i(p2_controls_i), .dipsw_i(dipsw_i),
		.dat_o(dat_o), .ack_o(ack_o)
	);

	//----------------------------
	// Video timing, independent of the bus
	//----------------------------
	video_timing u_video (
		.clk_49m(clk_49m), .reset(reset),
		.h_center_i(h_center_i), .v_center_i(v_center_i), .irq_ack_i(irq_ack_i),
		.ce_pix_o(ce_pix_o), .hblank_o(hblank_o), .vblank_o(vblank_o),
		.hsync_o(hsync_o), .vsync_o(vsync_o), .csync_o(csync_o), .irq_n_o(irq_n_o)
	);

endmodule

`default_nettype wire

// ==== verilog/video_timing.sv ====
//----------------------------
// Video timing generator
// Pixel enable, 320x264 raster, syncs and vblank interrupt
//----------------------------
`default_nettype none

module video_timing (
	input  wire                                clk_49m,
	input  wire                                reset,      // Active low
	input  wire  [blueprint_pkg::CENTER_W-1:0] h_center_i,
	input  wire  [blueprint_pkg::CENTER_W-1:0] v_center_i,
	input  wire                                irq_ack_i,
	output logic                               ce_pix_o,
	output logic                               hblank_o,
	output logic                               vblank_o,
	output logic                               hsync_o,
	output logic                               vsync_o,
	output logic                               csync_o,
	output logic                               irq_n_o
);

	localparam int PAD_W = blueprint_pkg::CNT_W - blueprint_pkg::CENTER_W;

	logic [9:0]                      frac_acc;
	logic [10:0]                     frac_sum;   // One extra bit for the compare
	logic                            frac_hit;
	logic [blueprint_pkg::CNT_W-1:0] h_cnt;
	logic [blueprint_pkg::CNT_W-1:0] v_cnt;
	logic [blueprint_pkg::CNT_W-1:0] hs_start;
	logic [blueprint_pkg::CNT_W-1:0] hs_end;
	logic [blueprint_pkg::CNT_W-1:0] vs_start;
	logic [blueprint_pkg::CNT_W-1:0] vs_end;
	logic                            vblank_d;

	//----------------------------
	// Fractional pixel enable
	//----------------------------
	assign frac_sum = {1'b0, frac_acc} + {1'b0, blueprint_pkg::CEN_N};
	assign frac_hit = (frac_sum >= {1'b0, blueprint_pkg::CEN_M});

	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			frac_acc <= '0;
			ce_pix_o <= 1'b0;
		end else begin
			ce_pix_o <= frac_hit;
			if (frac_hit)
				frac_acc <= 10'(frac_sum - {1'b0, blueprint_pkg::CEN_M}); // Keep remainder
			else
				frac_acc <= frac_sum[9:0];
		end
	end

	//----------------------------
	// Raster counters
	//----------------------------
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (ce_pix_o) begin
			if (h_cnt == blueprint_pkg::H_TOTAL - 9'd1) begin
				h_cnt <= '0;
				if (v_cnt == blueprint_pkg::V_TOTAL - 9'd1)
					v_cnt <= '0;
				else
					v_cnt <= v_cnt + 9'd1;
			end else begin
				h_cnt <= h_cnt + 9'd1;
			end
		end
	end

	// Blanking, visible area is 256 x 224
	assign hblank_o = (h_cnt >= blueprint_pkg::H_ACTIVE);
	assign vblank_o = (v_cnt < blueprint_pkg::V_ACTIVE_START) |
		(v_cnt >= blueprint_pkg::V_ACTIVE_END);

	// Syncs shifted by the screen centering offsets
	assign hs_start = blueprint_pkg::HS_BASE + {{PAD_W{1'b0}}, h_center_i};
	assign hs_end   = hs_start + blueprint_pkg::HS_WIDTH;
	assign vs_start = blueprint_pkg::VS_BASE + {{PAD_W{1'b0}}, v_center_i};
	assign vs_end   = vs_start + blueprint_pkg::VS_WIDTH;

	assign hsync_o = (h_cnt >= hs_start) && (h_cnt < hs_end);
	assign vsync_o = (v_cnt >= vs_start) && (v_cnt < vs_end);
	assign csync_o = ~(hsync_o ^ vsync_o);

	//----------------------------
	// Frame interrupt
	//----------------------------
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			irq_n_o  <= 1'b1;
			vblank_d <= 1'b0;
		end else begin
			vblank_d <= vblank_o;
			if (irq_ack_i)
				irq_n_o <= 1'b1;                   // Acknowledge beats a new edge
			else if (vblank_o && !vblank_d)
				irq_n_o <= 1'b0;
		end
	end

	a_h_in_range: assert property (@(posedge clk_49m) disable iff (!reset)
		h_cnt < blueprint_pkg::H_TOTAL)
	else $error("video_timing: h_cnt out of range %0d", h_cnt);

endmodule

`default_nettype wire

// ==== verilog/bus_result.sv ====
//----------------------------
// Bus result stage
// Read data select and acknowledge
//----------------------------
`default_nettype none

module bus_result (
	input  wire                                clk_49m,
	input  wire                                reset,      // Active low
	input  wire                                done_i,
	input  wire  [blueprint_pkg::REGION_W-1:0] region_i,
	input  wire  [1:0]                         port_sel_i,
	input  wire  [blueprint_pkg::DATA_W-1:0]   wram_q_i,
	input  wire  [blueprint_pkg::DATA_W-1:0]   p1_controls_i,
	input  wire  [blueprint_pkg::DATA_W-1:0]   p2_controls_i,
	input  wire  [blueprint_pkg::DATA_W-1:0]   dipsw_i,
	output logic [blueprint_pkg::DATA_W-1:0]   dat_o,
	output logic                               ack_o
);

	logic [blueprint_pkg::DATA_W-1:0] rd_val;

	// Read mux, anything not readable floats high
	always_comb begin
		rd_val = blueprint_pkg::OPEN_BUS;
		if (region_i == blueprint_pkg::REG_WRAM) begin
			rd_val = wram_q_i;
		end else if (region_i == blueprint_pkg::REG_INPUT) begin
			case (port_sel_i)
				blueprint_pkg::PORT_P1:  rd_val = p1_controls_i;
				blueprint_pkg::PORT_P2:  rd_val = p2_controls_i;
				blueprint_pkg::PORT_DIP: rd_val = dipsw_i;  // Readback from sound board
				default:                 rd_val = blueprint_pkg::OPEN_BUS;
			endcase
		end
	end

	always_ff @(posedge clk_49m) begin
		if (!reset)
			ack_o <= 1'b0;
		else
			ack_o <= done_i;
	end

	always_ff @(posedge clk_49m) begin
		if (done_i)
			dat_o <= rd_val;                   // Held until the next access
	end

	a_ack_single: assert property (@(posedge clk_49m) disable iff (!reset)
		ack_o |=> !ack_o)
	else $error("bus_result: ack held for two cycles");

endmodule

`default_nettype wire

// ==== verilog/bus_execute.sv ====
//----------------------------
// Bus access stage
// Work RAM, sound latch and screen control writes
//----------------------------
`default_nettype none

module bus_execute (
	input  wire                                clk_49m,
	input  wire                                reset,      // Active low
	input  wire                                cyc_i,
	input  wire                                stb_i,
	input  wire                                we_i,
	input  wire  [blueprint_pkg::ADDR_W-1:0]   adr_i,
	input  wire  [blueprint_pkg::DATA_W-1:0]   dat_i,
	input  wire  [blueprint_pkg::REGION_W-1:0] region_i,
	input  wire  [1:0]                         port_sel_i,
	output logic                               done_o,
	output logic [blueprint_pkg::REGION_W-1:0] region_o,
	output logic [1:0]                         port_sel_o,
	output logic [blueprint_pkg::DATA_W-1:0]   wram_q_o,
	output logic [blueprint_pkg::DATA_W-1:0]   sound_cmd_o,
	output logic                               sound_cmd_wr_o,
	output logic                               flip_o,
	output logic                               gfx_bank_o
);

	logic [blueprint_pkg::DATA_W-1:0] wram [0:(1 << blueprint_pkg::WRAM_AW)-1];

	logic [1:0] busy_cnt;  // 3 = done cycle, 2 = ack cycle, 1 = after ack
	logic       busy;
	logic       accept;
	logic       wr_wram;
	logic       wr_snd;
	logic       wr_ctrl;

	assign busy   = (busy_cnt != 2'd0);
	assign accept = cyc_i & stb_i & ~busy;   // Held strobe is masked until ack has passed

	assign wr_wram = accept & we_i & (region_i == blueprint_pkg::REG_WRAM);
	assign wr_snd  = accept & we_i & (region_i == blueprint_pkg::REG_SNDCMD);
	assign wr_ctrl = accept & we_i & (region_i == blueprint_pkg::REG_CTRL);

	//----------------------------
	// Access sequencing
	//----------------------------
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			busy_cnt <= 2'd0;
			done_o   <= 1'b0;
			region_o <= blueprint_pkg::REG_NONE;
		end else begin
			done_o <= accept;                  // Result stage acks on the next edge
			if (accept) begin
				busy_cnt <= 2'd3;
				region_o <= region_i;
			end else if (busy) begin
				busy_cnt <= busy_cnt - 2'd1;
			end
		end
	end

	// Port select for the input port mux
	always_ff @(posedge clk_49m) begin
		if (accept)
			port_sel_o <= port_sel_i;
	end

	//----------------------------
	// Work RAM with synchronous read
	//----------------------------
	always_ff @(posedge clk_49m) begin
		if (wr_wram)
			wram[adr_i[blueprint_pkg::WRAM_AW-1:0]] <= dat_i;
		if (accept)
			wram_q_o <= wram[adr_i[blueprint_pkg::WRAM_AW-1:0]]; // Old data on a write
	end

	//----------------------------
	// Board registers
	//----------------------------
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			sound_cmd_o    <= '0;
			sound_cmd_wr_o <= 1'b0;
			flip_o         <= 1'b0;
			gfx_bank_o     <= 1'b0;
		end else begin
			sound_cmd_wr_o <= wr_snd;          // Strobe lines up with the new command
			if (wr_snd)
				sound_cmd_o <= dat_i;
			if (wr_ctrl) begin
				flip_o     <= ~dat_i[blueprint_pkg::CTRL_FLIP_BIT]; // Board wiring is inverted
				gfx_bank_o <= dat_i[blueprint_pkg::CTRL_BANK_BIT];
			end
		end
	end

	// A new access may only start once the previous one has fully retired
	a_done_not_pending: assert property (@(posedge clk_49m) disable iff (!reset)
		done_o |-> !$past(done_o) && !$past(done_o, 2) && !$past(done_o, 3))
	else $error("bus_execute: done raised while an access was pending");

endmodule

`default_nettype wire

// ==== verilog/bus_decode.sv ====
//----------------------------
// Bus address decoder
// Maps an address to one of the board regions
//----------------------------
`default_nettype none

module bus_decode (
	input  wire  [blueprint_pkg::ADDR_W-1:0]   adr_i,
	output logic [blueprint_pkg::REGION_W-1:0] region_o,
	output logic [1:0]                         port_sel_o
);

	logic [4:0] adr_hi5;   // Work RAM window
	logic [3:0] adr_page;  // 4 KB page for the I/O registers

	assign adr_hi5  = adr_i[blueprint_pkg::ADDR_W-1 -: 5];
	assign adr_page = adr_i[blueprint_pkg::ADDR_W-1 -: 4];

	// Input port select comes straight from the low address bits
	assign port_sel_o = adr_i[1:0];

	//----------------------------
	// Region match
	//----------------------------
	always_comb begin
		region_o = blueprint_pkg::REG_NONE;          // ROM, video RAMs and holes
		if (adr_hi5 == blueprint_pkg::WRAM_BASE_HI) begin
			region_o = blueprint_pkg::REG_WRAM;
		end else begin
			case (adr_page)
				blueprint_pkg::INPUT_PAGE:  region_o = blueprint_pkg::REG_INPUT;
				blueprint_pkg::SNDCMD_PAGE: region_o = blueprint_pkg::REG_SNDCMD;
				blueprint_pkg::CTRL_PAGE:   region_o = blueprint_pkg::REG_CTRL;
				default:                    region_o = blueprint_pkg::REG_NONE;
			endcase
		end
	end

	// Downstream muxes only know these five codes
	always_comb begin
		assert (region_o == blueprint_pkg::REG_NONE ||
			region_o == blueprint_pkg::REG_WRAM ||
			region_o == blueprint_pkg::REG_INPUT ||
			region_o == blueprint_pkg::REG_SNDCMD ||
			region_o == blueprint_pkg::REG_CTRL)
		else $error("bus_decode: undefined region code %0d", region_o);
	end

endmodule

`default_nettype wire

// ==== verilog/blueprint_pkg.sv ====
//----------------------------
// Blue Print main board constants
// Memory map, region codes, bus widths and video timing
//----------------------------
`default_nettype none

package blueprint_pkg;

	//----------------------------
	// Bus sizes
	//----------------------------
	localparam int ADDR_W  = 16;                // Z80 address space
	localparam int DATA_W  = 8;
	localparam int WRAM_AW = 11;                // 2 KB work RAM

	//----------------------------
	// Region codes
	//----------------------------
	localparam int REGION_W = 3;
	localparam logic [REGION_W-1:0] REG_NONE   = 3'd0; // Unmapped, reads as open bus
	localparam logic [REGION_W-1:0] REG_WRAM   = 3'd1;
	localparam logic [REGION_W-1:0] REG_INPUT  = 3'd2;
	localparam logic [REGION_W-1:0] REG_SNDCMD = 3'd3;
	localparam logic [REGION_W-1:0] REG_CTRL   = 3'd4;

	// Address matches on the upper bits
	localparam logic [4:0] WRAM_BASE_HI = 5'b10000;   // 0x8000-0x87FF
	localparam logic [3:0] INPUT_PAGE   = 4'hC;
	localparam logic [3:0] SNDCMD_PAGE  = 4'hD;
	localparam logic [3:0] CTRL_PAGE    = 4'hE;

	// Input port selects, address bits 1:0
	localparam logic [1:0] PORT_P1  = 2'd0;
	localparam logic [1:0] PORT_P2  = 2'd1;
	localparam logic [1:0] PORT_DIP = 2'd3;        // Select 2 has no port

	localparam logic [DATA_W-1:0] OPEN_BUS = 8'hFF;
	localparam int CTRL_FLIP_BIT = 1;              // Flip is stored inverted
	localparam int CTRL_BANK_BIT = 2;

	//----------------------------
	// Video timing
	//----------------------------
	localparam int CNT_W    = 9;
	localparam int CENTER_W = 4;
	localparam logic [9:0] CEN_N = 10'd89;         // 49.152 MHz * 89/875 ~ 5 MHz
	localparam logic [9:0] CEN_M = 10'd875;
	localparam logic [CNT_W-1:0] H_TOTAL        = 9'd320;
	localparam logic [CNT_W-1:0] V_TOTAL        = 9'd264;
	localparam logic [CNT_W-1:0] H_ACTIVE       = 9'd256;
	localparam logic [CNT_W-1:0] V_ACTIVE_START = 9'd16;
	localparam logic [CNT_W-1:0] V_ACTIVE_END   = 9'd240;
	localparam logic [CNT_W-1:0] HS_BASE  = 9'd280;
	localparam logic [CNT_W-1:0] HS_WIDTH = 9'd32;
	localparam logic [CNT_W-1:0] VS_BASE  = 9'd248;
	localparam logic [CNT_W-1:0] VS_WIDTH = 9'd4;

endpackage

`default_nettype wire
